// File: design/seq_defines.svh
// Sizing macros shared by the vector sequencer RTL and testbench
// Instruction and register counts, operand widths, unit queue depths

`ifndef SEQ_DEFINES_SVH
`define SEQ_DEFINES_SVH

// Number of instruction IDs that can be in flight
`define SEQ_NR_VINSN 8

// Architectural vector registers
`define SEQ_NR_VREGS 32

// Vector length field width
`define SEQ_VL_W 16

// Scalar operand and scalar result width
`define SEQ_ELEN 32

// Instruction queue depth of each functional unit
`define SEQ_ALU_DEPTH 2
`define SEQ_MUL_DEPTH 2
`define SEQ_LD_DEPTH 2
`define SEQ_ST_DEPTH 2
// Scalar moves block the dispatcher, so one slot is enough
`define SEQ_NONE_DEPTH 1

// Occupancy counter width, must hold the largest depth
`define SEQ_CNT_W 2

`endif

// File: design/seq_isa_pkg.sv
// Vector ISA view of the sequencer
// Op and unit encodings, register index type, op decode functions

`include "seq_defines.svh"

package seq_isa_pkg;

  // Ops are grouped by unit so that decode can use ranges
  typedef enum logic [3:0] {
    VADD,
    VSUB,
    VAND,
    VOR,
    VMUL,
    VMACC,
    VLE,
    VSE,
    VMVXS
  } op_e;

  // Functional units, the value doubles as the row index of per-unit arrays
  typedef enum logic [2:0] {
    ALU   = 3'd0,
    MUL   = 3'd1,
    LOAD  = 3'd2,
    STORE = 3'd3,
    NONE  = 3'd4
  } unit_e;

  localparam int unsigned NR_UNITS = 5;

  // Vector register index
  typedef logic [$clog2(`SEQ_NR_VREGS)-1:0] vreg_t;

  // Unit that executes a given op
  function automatic unit_e op_unit(op_e op);
    unique case (op) inside
      [VADD:VOR]:   op_unit = ALU;
      [VMUL:VMACC]: op_unit = MUL;
      VLE:          op_unit = LOAD;
      VSE:          op_unit = STORE;
      default:      op_unit = NONE;
    endcase
  endfunction

  // Scalar moves return a value to the dispatcher
  function automatic logic is_scalar_move(op_e op);
    is_scalar_move = (op == VMVXS);
  endfunction

endpackage

// File: design/seq_ctrl_pkg.sv
// Sequencer control view
// Instruction IDs, register access entries, request and response structs,
// global hazard table type

`include "seq_defines.svh"

package seq_ctrl_pkg;

  // Instruction ID and one-bit-per-ID vector
  typedef logic [$clog2(`SEQ_NR_VINSN)-1:0] vid_t;
  typedef logic [`SEQ_NR_VINSN-1:0]         vid_vec_t;

  // Last instruction that touched a register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

  // Request from the scalar-core dispatcher
  typedef struct packed {
    seq_isa_pkg::op_e          op;
    seq_isa_pkg::vreg_t        vs1;
    logic                      use_vs1;
    seq_isa_pkg::vreg_t        vs2;
    logic                      use_vs2;
    seq_isa_pkg::vreg_t        vd;
    logic                      use_vd;
    logic [`SEQ_ELEN-1:0]      scalar_op;
    logic [`SEQ_VL_W-1:0]      vl;
  } seq_req_t;

  // Request issued to the processing units
  typedef struct packed {
    vid_t                      id;
    seq_isa_pkg::op_e          op;
    seq_isa_pkg::unit_e        unit;
    seq_isa_pkg::vreg_t        vs1;
    logic                      use_vs1;
    seq_isa_pkg::vreg_t        vs2;
    logic                      use_vs2;
    seq_isa_pkg::vreg_t        vd;
    logic                      use_vd;
    logic [`SEQ_ELEN-1:0]      scalar_op;
    logic [`SEQ_VL_W-1:0]      vl;
    // IDs this instruction must wait for, per operand
    vid_vec_t                  hazard_vs1;
    vid_vec_t                  hazard_vs2;
    vid_vec_t                  hazard_vd;
  } pe_req_t;

  // Completion report, one finished-ID vector per unit, indexed by unit_e
  typedef struct packed {
    vid_vec_t [seq_isa_pkg::NR_UNITS-1:0] done;
  } unit_resp_t;

  // Row N lists the instructions that instruction N depends on
  typedef vid_vec_t [`SEQ_NR_VINSN-1:0] hazard_table_t;

endpackage

// File: design/vinsn_tracker.sv
// Running-instruction tracker
// Per-unit matrix of running IDs, lowest free ID search and idle flag

`timescale 1ns/1ns

`include "seq_defines.svh"

module vinsn_tracker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Issue strobe from the sequencer
  input  logic                    issue_i,
  input  seq_ctrl_pkg::vid_t      issue_id_i,
  input  seq_isa_pkg::unit_e      issue_unit_i,
  // Completions from the units
  input  seq_ctrl_pkg::unit_resp_t unit_resp_i,
  // Allocation
  output seq_ctrl_pkg::vid_t      next_id_o,
  output logic                    full_o,
  // Running vector after this cycle's updates
  output seq_ctrl_pkg::vid_vec_t  running_o,
  output logic                    idle_o
);

  // One row per unit, one column per instruction ID
  seq_ctrl_pkg::vid_vec_t [seq_isa_pkg::NR_UNITS-1:0] run_q, run_d;

  // Registered running vector, OR over the unit rows
  seq_ctrl_pkg::vid_vec_t running_q;

  ////////////////////////////////////////////////////
  // Matrix update
  ////////////////////////////////////////////////////

  always_comb begin
    running_q = '0;
    running_o = '0;
    for (int u = 0; u < seq_isa_pkg::NR_UNITS; u++) begin
      // A unit only clears IDs of its own row
      run_d[u]  = run_q[u] & ~unit_resp_i.done[u];
      running_q = running_q | run_q[u];
    end
    // New instruction runs on its target unit
    if (issue_i) begin
      run_d[issue_unit_i][issue_id_i] = 1'b1;
    end
    for (int u = 0; u < seq_isa_pkg::NR_UNITS; u++) begin
      running_o = running_o | run_d[u];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q <= '0;
    end else begin
      run_q <= run_d;
    end
  end

  ////////////////////////////////////////////////////
  // Free ID search
  ////////////////////////////////////////////////////

  // Scan from the top so the lowest free ID wins
  always_comb begin
    next_id_o = '0;
    for (int i = `SEQ_NR_VINSN - 1; i >= 0; i--) begin
      if (!running_q[i]) begin
        next_id_o = seq_ctrl_pkg::vid_t'(i);
      end
    end
  end

  // No ID left to hand out
  assign full_o = &running_q;

  // Nothing in flight on any unit
  assign idle_o = ~(|running_q);

endmodule

// File: design/hazard_checker.sv
// Hazard checker
// Read and write lists of the vector registers, RAW/WAR/WAW vector
// generation for the presented request, list update on issue

`timescale 1ns/1ns

`include "seq_defines.svh"

module hazard_checker (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Presented request and running set after this cycle's completions
  input  seq_ctrl_pkg::seq_req_t req_i,
  input  seq_ctrl_pkg::vid_vec_t running_i,
  // Issue strobe
  input  logic                   issue_i,
  input  seq_ctrl_pkg::vid_t     issue_id_i,
  // Hazard vectors for the presented request
  output seq_ctrl_pkg::vid_vec_t hazard_vs1_o,
  output seq_ctrl_pkg::vid_vec_t hazard_vs2_o,
  output seq_ctrl_pkg::vid_vec_t hazard_vd_o
);

  // Last reader and last writer of each register
  seq_ctrl_pkg::vreg_access_t [`SEQ_NR_VREGS-1:0] read_list_q, read_list_d;
  seq_ctrl_pkg::vreg_access_t [`SEQ_NR_VREGS-1:0] write_list_q, write_list_d;

  // Operand indices of the presented request
  seq_isa_pkg::vreg_t vs1, vs2, vd;

  // List entries for those operands, already aged by completions
  seq_ctrl_pkg::vreg_access_t vs1_writer, vs2_writer, vd_writer, vd_reader;

  assign vs1 = req_i.vs1;
  assign vs2 = req_i.vs2;
  assign vd  = req_i.vd;

  ////////////////////////////////////////////////////
  // List aging and update
  ////////////////////////////////////////////////////

  always_comb begin
    read_list_d  = read_list_q;
    write_list_d = write_list_q;

    // Entries die with their instruction
    for (int v = 0; v < `SEQ_NR_VREGS; v++) begin
      read_list_d[v].valid  = read_list_q[v].valid & running_i[read_list_q[v].vid];
      write_list_d[v].valid = write_list_q[v].valid & running_i[write_list_q[v].vid];
    end

    // Snapshot for hazard lookup, before this issue overwrites anything
    vs1_writer = write_list_d[vs1];
    vs2_writer = write_list_d[vs2];
    vd_writer  = write_list_d[vd];
    vd_reader  = read_list_d[vd];

    // Record the new instruction as reader and writer
    if (issue_i) begin
      if (req_i.use_vd) begin
        write_list_d[vd] = '{vid: issue_id_i, valid: 1'b1};
      end
      if (req_i.use_vs1) begin
        read_list_d[vs1] = '{vid: issue_id_i, valid: 1'b1};
      end
      if (req_i.use_vs2) begin
        read_list_d[vs2] = '{vid: issue_id_i, valid: 1'b1};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_list_q  <= '0;
      write_list_q <= '0;
    end else begin
      read_list_q  <= read_list_d;
      write_list_q <= write_list_d;
    end
  end

  ////////////////////////////////////////////////////
  // Hazard vectors
  ////////////////////////////////////////////////////

  always_comb begin
    hazard_vs1_o = '0;
    hazard_vs2_o = '0;
    hazard_vd_o  = '0;

    // RAW, wait for the producer of each source
    if (req_i.use_vs1 && vs1_writer.valid) begin
      hazard_vs1_o[vs1_writer.vid] = 1'b1;
    end
    if (req_i.use_vs2 && vs2_writer.valid) begin
      hazard_vs2_o[vs2_writer.vid] = 1'b1;
    end

    // WAR, the last reader of vd must fetch its operand first
    if (req_i.use_vd && vd_reader.valid) begin
      hazard_vs1_o[vd_reader.vid] = 1'b1;
      hazard_vs2_o[vd_reader.vid] = 1'b1;
    end

    // WAW, keep writes to vd in order
    if (req_i.use_vd && vd_writer.valid) begin
      hazard_vd_o[vd_writer.vid] = 1'b1;
    end
  end

endmodule

// File: design/unit_queue_counters.sv
// Functional unit queue occupancy
// One counter per unit and the per-unit readiness flags

`timescale 1ns/1ns

`include "seq_defines.svh"

module unit_queue_counters (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Issue strobe and its target unit
  input  logic                                 issue_i,
  input  seq_isa_pkg::unit_e                   issue_unit_i,
  // Completions from the units
  input  seq_ctrl_pkg::unit_resp_t             unit_resp_i,
  // Unit can take one more instruction
  output logic [seq_isa_pkg::NR_UNITS-1:0]     unit_ready_o
);

  // Depth per unit, in unit_e order
  localparam logic [`SEQ_CNT_W-1:0] QUEUE_DEPTH [seq_isa_pkg::NR_UNITS] = '{
    `SEQ_CNT_W'(`SEQ_ALU_DEPTH),
    `SEQ_CNT_W'(`SEQ_MUL_DEPTH),
    `SEQ_CNT_W'(`SEQ_LD_DEPTH),
    `SEQ_CNT_W'(`SEQ_ST_DEPTH),
    `SEQ_CNT_W'(`SEQ_NONE_DEPTH)
  };

  logic [seq_isa_pkg::NR_UNITS-1:0][`SEQ_CNT_W-1:0] cnt_q;
  logic [seq_isa_pkg::NR_UNITS-1:0]                 cnt_up, cnt_down;

  for (genvar u = 0; u < seq_isa_pkg::NR_UNITS; u++) begin : gen_cnt
    // Count on issue, not on unit hand-off
    assign cnt_up[u] = issue_i && (issue_unit_i == seq_isa_pkg::unit_e'(u));

    // At most one ID per cycle, any bit means one slot freed
    assign cnt_down[u] = |unit_resp_i.done[u];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[u] <= '0;
      end else if (cnt_up[u] && !cnt_down[u]) begin
        cnt_q[u] <= cnt_q[u] + 1'b1;
      end else if (cnt_down[u] && !cnt_up[u]) begin
        cnt_q[u] <= cnt_q[u] - 1'b1;
      end
      // One in, one out leaves the count as is
    end

    // Room left in this unit's queue
    assign unit_ready_o[u] = cnt_q[u] < QUEUE_DEPTH[u];
  end

endmodule

// File: design/vector_sequencer.sv
// Vector instruction sequencer top level
// IDLE/WAIT controller, issue decision, issued request register,
// global hazard table and scalar move response path

`timescale 1ns/1ns

`include "seq_defines.svh"

module vector_sequencer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Dispatcher
  input  seq_ctrl_pkg::seq_req_t        req_i,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  output logic [`SEQ_ELEN-1:0]          resp_o,
  output logic                          resp_valid_o,
  output logic                          idle_o,
  // Processing units
  output seq_ctrl_pkg::pe_req_t         pe_req_o,
  output logic                          pe_req_valid_o,
  input  logic                          pe_req_ready_i,
  input  seq_ctrl_pkg::unit_resp_t      unit_resp_i,
  // Scalar result of a move
  input  logic [`SEQ_ELEN-1:0]          scalar_resp_i,
  input  logic                          scalar_resp_valid_i,
  output logic                          scalar_resp_ready_o,
  // Operand requesters
  output seq_ctrl_pkg::hazard_table_t   hazard_table_o
);

  // WAIT blocks the dispatcher until a scalar move returns
  typedef enum logic {IDLE, WAIT} state_e;
  state_e state_q, state_d;

  seq_isa_pkg::unit_e                   req_unit;
  logic [seq_isa_pkg::NR_UNITS-1:0]     unit_ready;
  seq_ctrl_pkg::vid_t                   next_id;
  logic                                 ids_full;
  seq_ctrl_pkg::vid_vec_t               running;
  seq_ctrl_pkg::vid_vec_t               hz_vs1, hz_vs2, hz_vd;
  logic                                 pending, issue;
  seq_ctrl_pkg::hazard_table_t          table_d;

  ////////////////////////////////////////////////////
  // Issue decision
  ////////////////////////////////////////////////////

  assign req_unit = seq_isa_pkg::op_unit(req_i.op);

  // Issued request still waiting for the units
  assign pending = pe_req_valid_o && !pe_req_ready_i;

  assign req_ready_o = (state_q == IDLE) && !ids_full && unit_ready[req_unit] && !pending;
  assign issue       = req_valid_i && req_ready_o;

  vinsn_tracker i_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_i      (issue),
    .issue_id_i   (next_id),
    .issue_unit_i (req_unit),
    .unit_resp_i  (unit_resp_i),
    .next_id_o    (next_id),
    .full_o       (ids_full),
    .running_o    (running),
    .idle_o       (idle_o)
  );

  hazard_checker i_hazards (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .running_i    (running),
    .issue_i      (issue),
    .issue_id_i   (next_id),
    .hazard_vs1_o (hz_vs1),
    .hazard_vs2_o (hz_vs2),
    .hazard_vd_o  (hz_vd)
  );

  unit_queue_counters i_counters (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_i      (issue),
    .issue_unit_i (req_unit),
    .unit_resp_i  (unit_resp_i),
    .unit_ready_o (unit_ready)
  );

  ////////////////////////////////////////////////////
  // Issued request
  ////////////////////////////////////////////////////

  // Valid drops once taken, new issue reloads it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_req_valid_o <= 1'b0;
    end else if (issue) begin
      pe_req_valid_o <= 1'b1;
    end else if (pe_req_ready_i) begin
      pe_req_valid_o <= 1'b0;
    end
  end

  // Payload only loads on issue, so it holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (issue) begin
      pe_req_o <= '{
        id:         next_id,
        op:         req_i.op,
        unit:       req_unit,
        vs1:        req_i.vs1,
        use_vs1:    req_i.use_vs1,
        vs2:        req_i.vs2,
        use_vs2:    req_i.use_vs2,
        vd:         req_i.vd,
        use_vd:     req_i.use_vd,
        scalar_op:  req_i.scalar_op,
        vl:         req_i.vl,
        hazard_vs1: hz_vs1,
        hazard_vs2: hz_vs2,
        hazard_vd:  hz_vd
      };
    end
  end

  ////////////////////////////////////////////////////
  // Global hazard table
  ////////////////////////////////////////////////////

  always_comb begin
    table_d = hazard_table_o;
    if (issue) begin
      table_d[next_id] = hz_vs1 | hz_vs2 | hz_vd;
    end
    // Finished producers release every dependent row
    for (int r = 0; r < `SEQ_NR_VINSN; r++) begin
      table_d[r] = table_d[r] & running;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hazard_table_o <= '0;
    end else begin
      hazard_table_o <= table_d;
    end
  end

  ////////////////////////////////////////////////////
  // Controller and scalar response
  ////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: if (issue && seq_isa_pkg::is_scalar_move(req_i.op)) state_d = WAIT;
      WAIT: if (scalar_resp_valid_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Result passes straight through to the dispatcher
  assign resp_o              = scalar_resp_i;
  assign resp_valid_o        = (state_q == WAIT) && scalar_resp_valid_i;
  assign scalar_resp_ready_o = (state_q == WAIT) && scalar_resp_valid_i;

endmodule

// File: testbench/seq_properties.sv
// Concurrent assertions for the vector sequencer top level
// Issued request hold under back-pressure, scalar response timing, reset values

`timescale 1ns/1ns

module seq_properties (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        req_valid_i,
  input seq_isa_pkg::op_e            req_op_i,
  input logic                        req_ready_i,
  input logic                        resp_valid_i,
  input logic                        idle_i,
  input seq_ctrl_pkg::pe_req_t       pe_req_i,
  input logic                        pe_req_valid_i,
  input logic                        pe_req_ready_i,
  input logic                        scalar_resp_ready_i,
  input seq_ctrl_pkg::hazard_table_t hazard_table_i
);

  // Failed assertions, read by the testbench verdict
  int unsigned fail_count = 0;

  // Scalar move accepted and its result not yet returned
  logic move_pending_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      move_pending_q <= 1'b0;
    end else if (resp_valid_i) begin
      move_pending_q <= 1'b0;
    end else if (req_valid_i && req_ready_i && (req_op_i == seq_isa_pkg::VMVXS)) begin
      move_pending_q <= 1'b1;
    end
  end

  // A request that is not taken stays valid and unchanged
  a_pe_req_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      (pe_req_valid_i && !pe_req_ready_i) |=> (pe_req_valid_i && $stable(pe_req_i))
  ) else begin
    fail_count++;
    $error("issued request changed or dropped while the units were not ready");
  end

  // Scalar result only goes out while a move is outstanding
  a_resp_in_wait: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      resp_valid_i |-> move_pending_q
  ) else begin
    fail_count++;
    $error("resp_valid_o raised with no scalar move outstanding");
  end

  // Quiet, ready and empty during reset
  a_reset_values: assert property (
    @(posedge clk_i)
      !rst_ni |-> (!pe_req_valid_i && !resp_valid_i && !scalar_resp_ready_i &&
                   req_ready_i && idle_i && (hazard_table_i == '0))
  ) else begin
    fail_count++;
    $error("outputs do not hold their reset values during reset");
  end

endmodule

bind vector_sequencer seq_properties i_seq_props (
  .clk_i               (clk_i),
  .rst_ni              (rst_ni),
  .req_valid_i         (req_valid_i),
  .req_op_i            (req_i.op),
  .req_ready_i         (req_ready_o),
  .resp_valid_i        (resp_valid_o),
  .idle_i              (idle_o),
  .pe_req_i            (pe_req_o),
  .pe_req_valid_i      (pe_req_valid_o),
  .pe_req_ready_i      (pe_req_ready_i),
  .scalar_resp_ready_i (scalar_resp_ready_o),
  .hazard_table_i      (hazard_table_o)
);

// File: testbench/tb_vector_sequencer.sv
// Directed testbench for the vector sequencer
// Clock and reset, request and completion drivers, typed compare tasks,
// one task per tested behavior and the final verdict

`timescale 1ns/1ns

`include "seq_defines.svh"

module tb_vector_sequencer;

  localparam int CLK_PERIOD = 40;
  // Upper bound in cycles for any single wait
  localparam int MAX_WAIT   = 50;

  logic                        clk_i;
  logic                        rst_ni;
  seq_ctrl_pkg::seq_req_t      req_i;
  logic                        req_valid_i;
  logic                        req_ready_o;
  logic [`SEQ_ELEN-1:0]        resp_o;
  logic                        resp_valid_o;
  logic                        idle_o;
  seq_ctrl_pkg::pe_req_t       pe_req_o;
  logic                        pe_req_valid_o;
  logic                        pe_req_ready_i;
  seq_ctrl_pkg::unit_resp_t    unit_resp_i;
  logic [`SEQ_ELEN-1:0]        scalar_resp_i;
  logic                        scalar_resp_valid_i;
  logic                        scalar_resp_ready_o;
  seq_ctrl_pkg::hazard_table_t hazard_table_o;

  integer seed;
  int     errors;
  int     timeouts;

  vector_sequencer UUT (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .req_i               (req_i),
    .req_valid_i         (req_valid_i),
    .req_ready_o         (req_ready_o),
    .resp_o              (resp_o),
    .resp_valid_o        (resp_valid_o),
    .idle_o              (idle_o),
    .pe_req_o            (pe_req_o),
    .pe_req_valid_o      (pe_req_valid_o),
    .pe_req_ready_i      (pe_req_ready_i),
    .unit_resp_i         (unit_resp_i),
    .scalar_resp_i       (scalar_resp_i),
    .scalar_resp_valid_i (scalar_resp_valid_i),
    .scalar_resp_ready_o (scalar_resp_ready_o),
    .hazard_table_o      (hazard_table_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_pe_req(input string name, input seq_ctrl_pkg::pe_req_t act,
                              input seq_ctrl_pkg::pe_req_t exp);
    if (act !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_vid_vec(input string name, input seq_ctrl_pkg::vid_vec_t act,
                               input seq_ctrl_pkg::vid_vec_t exp);
    if (act !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s is %b, expected %b", $time, name, act, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [`SEQ_ELEN-1:0] act,
                            input logic [`SEQ_ELEN-1:0] exp);
    if (act !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s is %b, expected %b", $time, name, act, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Random register inside an 8-register group starting at base
  function automatic seq_isa_pkg::vreg_t pick_reg(input int base);
    return seq_isa_pkg::vreg_t'(base + ($unsigned($random(seed)) % 8));
  endfunction

  // Use bits are {vs1, vs2, vd}, operand and length are random
  function automatic seq_ctrl_pkg::seq_req_t make_req(input seq_isa_pkg::op_e op,
      input int vs1, input int vs2, input int vd, input logic [2:0] use_bits);
    seq_ctrl_pkg::seq_req_t r;
    r.op        = op;
    r.vs1       = seq_isa_pkg::vreg_t'(vs1);
    r.use_vs1   = use_bits[2];
    r.vs2       = seq_isa_pkg::vreg_t'(vs2);
    r.use_vs2   = use_bits[1];
    r.vd        = seq_isa_pkg::vreg_t'(vd);
    r.use_vd    = use_bits[0];
    r.scalar_op = $random(seed);
    r.vl        = $random(seed);
    return r;
  endfunction

  // Unit request that the dispatcher request should turn into
  function automatic seq_ctrl_pkg::pe_req_t expected_pe(input seq_ctrl_pkg::seq_req_t r,
      input int id, input seq_isa_pkg::unit_e unit, input seq_ctrl_pkg::vid_vec_t h1,
      input seq_ctrl_pkg::vid_vec_t h2, input seq_ctrl_pkg::vid_vec_t hd);
    seq_ctrl_pkg::pe_req_t p;
    p.id         = seq_ctrl_pkg::vid_t'(id);
    p.op         = r.op;
    p.unit       = unit;
    p.vs1        = r.vs1;
    p.use_vs1    = r.use_vs1;
    p.vs2        = r.vs2;
    p.use_vs2    = r.use_vs2;
    p.vd         = r.vd;
    p.use_vd     = r.use_vd;
    p.scalar_op  = r.scalar_op;
    p.vl         = r.vl;
    p.hazard_vs1 = h1;
    p.hazard_vs2 = h2;
    p.hazard_vd  = hd;
    return p;
  endfunction

  // Entered on a falling edge, returns on the falling edge after the transfer
  task automatic send_req(input seq_ctrl_pkg::seq_req_t r);
    int   n;
    logic taken;
    n     = 0;
    taken = 1'b0;
    req_i       = r;
    req_valid_i = 1'b1;
    while (!taken && n < MAX_WAIT) begin
      // Ready settles well before the rising edge
      #(CLK_PERIOD / 4);
      taken = req_ready_o;
      @(negedge clk_i);
      n++;
    end
    req_valid_i = 1'b0;
    if (!taken) begin
      timeouts++;
      $display("Timeout at %0t: dispatcher request was never accepted", $time);
    end
  endtask

  task automatic expect_pe_req(input seq_ctrl_pkg::pe_req_t exp);
    int n;
    n = 0;
    while (!pe_req_valid_o && n < MAX_WAIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!pe_req_valid_o) begin
      timeouts++;
      $display("Timeout at %0t: no request was issued to the units", $time);
    end else begin
      check_pe_req("pe_req_o", pe_req_o, exp);
      // Units take it at the next edge, valid lasts one cycle
      if (pe_req_ready_i) begin
        @(negedge clk_i);
        check_bit("pe_req_valid_o", pe_req_valid_o, 1'b0);
      end
    end
  endtask

  task automatic issue_and_check(input seq_ctrl_pkg::seq_req_t r, input int id,
      input seq_isa_pkg::unit_e unit, input seq_ctrl_pkg::vid_vec_t h1,
      input seq_ctrl_pkg::vid_vec_t h2, input seq_ctrl_pkg::vid_vec_t hd);
    send_req(r);
    expect_pe_req(expected_pe(r, id, unit, h1, h2, hd));
  endtask

  // One-cycle done pulse from a unit
  task automatic complete(input seq_isa_pkg::unit_e unit, input int id);
    unit_resp_i.done[unit][id] = 1'b1;
    @(negedge clk_i);
    unit_resp_i = '0;
  endtask

  task automatic scalar_reply(input logic [`SEQ_ELEN-1:0] value);
    scalar_resp_i       = value;
    scalar_resp_valid_i = 1'b1;
    #(CLK_PERIOD / 4);
    check_bit("resp_valid_o", resp_valid_o, 1'b1);
    check_word("resp_o", resp_o, value);
    check_bit("scalar_resp_ready_o", scalar_resp_ready_o, 1'b1);
    @(negedge clk_i);
    scalar_resp_valid_i = 1'b0;
  endtask

  // Present a request that must not be accepted
  task automatic check_stalled(input seq_ctrl_pkg::seq_req_t r, input int cycles);
    req_i       = r;
    req_valid_i = 1'b1;
    repeat (cycles) begin
      #(CLK_PERIOD / 4);
      check_bit("req_ready_o", req_ready_o, 1'b0);
      @(negedge clk_i);
    end
    req_valid_i = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_alloc();
    int i;
    check_bit("idle_o", idle_o, 1'b1);
    for (i = 0; i < `SEQ_NR_VINSN; i++) begin
      check_vid_vec("hazard_table_o row", hazard_table_o[i], '0);
    end
    // Disjoint register groups, so no hazards
    issue_and_check(make_req(seq_isa_pkg::VADD, pick_reg(0), pick_reg(0), pick_reg(0), 3'b111),
                    0, seq_isa_pkg::ALU, '0, '0, '0);
    issue_and_check(make_req(seq_isa_pkg::VMUL, pick_reg(8), pick_reg(8), pick_reg(8), 3'b111),
                    1, seq_isa_pkg::MUL, '0, '0, '0);
    issue_and_check(make_req(seq_isa_pkg::VLE, 0, 0, pick_reg(16), 3'b001),
                    2, seq_isa_pkg::LOAD, '0, '0, '0);
    check_bit("idle_o", idle_o, 1'b0);
    complete(seq_isa_pkg::ALU, 0);
    complete(seq_isa_pkg::MUL, 1);
    complete(seq_isa_pkg::LOAD, 2);
    check_bit("idle_o", idle_o, 1'b1);
    // All IDs free again
    issue_and_check(make_req(seq_isa_pkg::VOR, pick_reg(24), pick_reg(24), pick_reg(24), 3'b111),
                    0, seq_isa_pkg::ALU, '0, '0, '0);
    complete(seq_isa_pkg::ALU, 0);
  endtask

  task automatic test_raw();
    issue_and_check(make_req(seq_isa_pkg::VADD, 1, 2, 3, 3'b111),
                    0, seq_isa_pkg::ALU, '0, '0, '0);
    // Reads v3 as vs2 while ID 0 still writes it
    issue_and_check(make_req(seq_isa_pkg::VMUL, 4, 3, 6, 3'b111),
                    1, seq_isa_pkg::MUL, '0, 8'h01, '0);
    check_vid_vec("hazard_table_o[1]", hazard_table_o[1], 8'h01);
    complete(seq_isa_pkg::ALU, 0);
    check_vid_vec("hazard_table_o[1]", hazard_table_o[1], 8'h00);
    // Producer gone, a new reader of v3 is free to go
    issue_and_check(make_req(seq_isa_pkg::VSUB, 3, 7, 8, 3'b111),
                    0, seq_isa_pkg::ALU, '0, '0, '0);
    complete(seq_isa_pkg::MUL, 1);
    complete(seq_isa_pkg::ALU, 0);
  endtask

  task automatic test_war_waw();
    // ID 0 reads v5
    issue_and_check(make_req(seq_isa_pkg::VADD, 5, 9, 10, 3'b111),
                    0, seq_isa_pkg::ALU, '0, '0, '0);
    // ID 1 writes v5, WAR against ID 0
    issue_and_check(make_req(seq_isa_pkg::VMUL, 11, 12, 5, 3'b111),
                    1, seq_isa_pkg::MUL, 8'h01, 8'h01, '0);
    // ID 2 writes v5, WAR against ID 0 and WAW against ID 1
    issue_and_check(make_req(seq_isa_pkg::VSUB, 13, 14, 5, 3'b111),
                    2, seq_isa_pkg::ALU, 8'h01, 8'h01, 8'h02);
    check_vid_vec("hazard_table_o[2]", hazard_table_o[2], 8'h03);
    complete(seq_isa_pkg::ALU, 0);
    complete(seq_isa_pkg::MUL, 1);
    complete(seq_isa_pkg::ALU, 2);
  endtask

  task automatic test_queue_limit();
    seq_ctrl_pkg::seq_req_t third;
    issue_and_check(make_req(seq_isa_pkg::VADD, 1, 2, 3, 3'b111),
                    0, seq_isa_pkg::ALU, '0, '0, '0);
    issue_and_check(make_req(seq_isa_pkg::VAND, 4, 5, 6, 3'b111),
                    1, seq_isa_pkg::ALU, '0, '0, '0);
    third = make_req(seq_isa_pkg::VSUB, 9, 10, 11, 3'b111);
    // ALU queue is full
    check_stalled(third, 4);
    // Other units keep accepting
    issue_and_check(make_req(seq_isa_pkg::VLE, 0, 0, 12, 3'b001),
                    2, seq_isa_pkg::LOAD, '0, '0, '0);
    complete(seq_isa_pkg::ALU, 0);
    issue_and_check(third, 0, seq_isa_pkg::ALU, '0, '0, '0);
    complete(seq_isa_pkg::ALU, 1);
    complete(seq_isa_pkg::LOAD, 2);
    complete(seq_isa_pkg::ALU, 0);
  endtask

  task automatic test_scalar_move();
    int                   gap;
    logic [`SEQ_ELEN-1:0] value;
    issue_and_check(make_req(seq_isa_pkg::VMVXS, 0, 2, 0, 3'b010),
                    0, seq_isa_pkg::NONE, '0, '0, '0);
    gap = 1 + ($unsigned($random(seed)) % 4);
    // Dispatcher blocked until the scalar result shows up
    repeat (gap) begin
      #(CLK_PERIOD / 4);
      check_bit("req_ready_o", req_ready_o, 1'b0);
      check_bit("resp_valid_o", resp_valid_o, 1'b0);
      @(negedge clk_i);
    end
    value = $random(seed);
    scalar_reply(value);
    complete(seq_isa_pkg::NONE, 0);
    #(CLK_PERIOD / 4);
    check_bit("req_ready_o", req_ready_o, 1'b1);
    @(negedge clk_i);
  endtask

  task automatic test_back_pressure();
    seq_ctrl_pkg::seq_req_t first;
    seq_ctrl_pkg::seq_req_t second;
    first  = make_req(seq_isa_pkg::VADD, 1, 2, 3, 3'b111);
    second = make_req(seq_isa_pkg::VLE, 0, 0, 4, 3'b001);
    pe_req_ready_i = 1'b0;
    issue_and_check(first, 0, seq_isa_pkg::ALU, '0, '0, '0);
    check_stalled(second, 4);
    // Still the first request, untouched
    expect_pe_req(expected_pe(first, 0, seq_isa_pkg::ALU, '0, '0, '0));
    pe_req_ready_i = 1'b1;
    issue_and_check(second, 1, seq_isa_pkg::LOAD, '0, '0, '0);
    complete(seq_isa_pkg::ALU, 0);
    complete(seq_isa_pkg::LOAD, 1);
  endtask

  //////////////////////////////////////////////////
  // Sequence and verdict
  //////////////////////////////////////////////////

  initial begin
    seed                = 32'hdb01b41f;
    errors              = 0;
    timeouts            = 0;
    rst_ni              = 1'b0;
    req_i               = '0;
    req_valid_i         = 1'b0;
    pe_req_ready_i      = 1'b1;
    unit_resp_i         = '0;
    scalar_resp_i       = '0;
    scalar_resp_valid_i = 1'b0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    test_alloc();
    test_raw();
    test_war_waw();
    test_queue_limit();
    test_scalar_move();
    test_back_pressure();

    @(negedge clk_i);
    $display("Summary: %0d errors, %0d timeouts, %0d assertion errors",
             errors, timeouts, UUT.i_seq_props.fail_count);
    if (errors == 0 && timeouts == 0 && UUT.i_seq_props.fail_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+design
design/seq_isa_pkg.sv
design/seq_ctrl_pkg.sv
design/vinsn_tracker.sv
design/hazard_checker.sv
design/unit_queue_counters.sv
design/vector_sequencer.sv
testbench/seq_properties.sv
testbench/tb_vector_sequencer.sv

// File: Bender.yml
package:
  name: vector_sequencer

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/seq_isa_pkg.sv
      - design/seq_ctrl_pkg.sv
      - design/vinsn_tracker.sv
      - design/hazard_checker.sv
      - design/unit_queue_counters.sv
      - design/vector_sequencer.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/seq_properties.sv
      - testbench/tb_vector_sequencer.sv
